//--- tb.f
src/calc_pkg.sv
src/key_entry.sv
src/token_fifo.sv
src/arith_unit.sv
src/bcd_converter.sv
src/calculator_top.sv
test/tb_calculator.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_calculator -o tb_calculator
	out=$$(./obj_dir/tb_calculator); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

//--- test/tb_calculator.sv
`timescale 1ns/1ps
`default_nettype none

module tb_calculator;

    typedef struct packed {
        logic                  neg;
        calc_pkg::bcd_result_t bcd;
    } result_t;

    localparam int num_expr        = 28;
    localparam int keys_per_expr   = 35;   // 5 terms of 6 digits plus 5 operators
    localparam int watchdog_cycles = 2 * num_expr * (keys_per_expr * 2 + 40) + 200;
    localparam int result_timeout  = calc_pkg::conv_steps + 20;

    logic                  rst;
    logic                  clk_100hz;
    calc_pkg::digit_keys_t digit_keys;
    calc_pkg::op_keys_t    op_keys;
    logic                  result_valid;
    logic                  result_neg;
    calc_pkg::bcd_result_t result_bcd;
    logic                  overflow;

    logic [31:0]   terms [6];
    calc_pkg::op_t ops [6];
    int            nterms;
    result_t       expected_q [$];
    int            results_expected = 0;
    int            results_seen = 0;
    int            value_errors = 0;
    int            protocol_errors = 0;
    logic [31:0]   lcg_state = 32'h8267;

    calculator_top u_dut (
        .rst          (rst),
        .clk_100hz    (clk_100hz),
        .digit_keys   (digit_keys),
        .op_keys      (op_keys),
        .result_valid (result_valid),
        .result_neg   (result_neg),
        .result_bcd   (result_bcd),
        .overflow     (overflow)
    );

    initial
    begin
        rst = 1'b0;
        forever #50 rst = ~rst;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // left to right from 0 with add pending and 32-bit wrap
    function automatic result_t calc_reference(input int n);
        logic signed [63:0] acc;
        logic signed [63:0] b;
        logic signed [63:0] mag;
        calc_pkg::op_t      pending;
        result_t            r;
        acc = 0;
        pending = calc_pkg::op_add;
        for (int i = 0; i < n; i++)
        begin
            b = 64'($signed(terms[i]));
            case (pending)
                calc_pkg::op_add: acc = acc + b;
                calc_pkg::op_sub: acc = acc - b;
                calc_pkg::op_mul: acc = acc * b;
                calc_pkg::op_div: acc = (b == 0) ? 64'sd0 : acc / b;
                default: acc = acc;
            endcase
            acc = 64'($signed(acc[31:0]));
            pending = ops[i];
        end
        r.neg = acc < 0;
        mag = (acc < 0) ? -acc : acc;   // 2^31 fits here
        r.bcd = '0;
        for (int k = 0; k < calc_pkg::bcd_digits; k++)
        begin
            r.bcd[4*k +: 4] = 4'(mag % 10);
            mag = mag / 10;
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        assert (got == want)
        else
        begin
            $display("Fail %s: got %h expected %h", name, got, want);
            value_errors++;
        end
    endtask

    task automatic apply_reset();
        clk_100hz = 1'b1;
        repeat (8) @(negedge rst);
        clk_100hz = 1'b0;
    endtask

    // one cycle high then one cycle low per press
    task automatic press_digit(input int d);
        digit_keys = calc_pkg::digit_keys_t'(1) << d;
        @(negedge rst);
        digit_keys = '0;
        @(negedge rst);
    endtask

    task automatic press_op(input calc_pkg::op_t op);
        op_keys = calc_pkg::op_keys_t'(1) << int'(op);
        @(negedge rst);
        op_keys = '0;
        @(negedge rst);
    endtask

    task automatic enter_number(input int unsigned value);
        int unsigned v;
        int          nd;
        int          dig [10];
        v = value;
        nd = 0;
        do
        begin
            dig[nd] = int'(v % 10);
            v = v / 10;
            nd++;
        end
        while (v != 0);
        for (int i = nd - 1; i >= 0; i--)
            press_digit(dig[i]);
    endtask

    task automatic load(input int idx, input int unsigned t, input calc_pkg::op_t o);
        terms[idx] = t;
        ops[idx] = o;
        nterms = idx + 1;
    endtask

    task automatic wait_result();
        int n;
        n = 0;
        while (results_seen != results_expected && n < result_timeout)
        begin
            @(posedge rst);
            n++;
        end
        if (results_seen != results_expected)
        begin
            $display("no result_valid pulse within %0d cycles after equals", result_timeout);
            protocol_errors++;
        end
        @(negedge rst);
    endtask

    task automatic run_expr(input int from);
        for (int i = from; i < nterms; i++)
        begin
            enter_number(terms[i]);
            if (ops[i] == calc_pkg::op_equ)
            begin
                expected_q.push_back(calc_reference(nterms));
                results_expected++;
            end
            press_op(ops[i]);
        end
        wait_result();
    endtask

    // checker samples on the falling edge
    initial
    begin
        result_t want;
        forever
        begin
            @(negedge rst);
            if (result_valid)
            begin
                results_seen++;
                if (expected_q.size() == 0)
                begin
                    $display("result_valid pulsed with no equals pending at %0t", $time);
                    protocol_errors++;
                end
                else
                begin
                    want = expected_q.pop_front();
                    check_value("result_neg", 64'(result_neg), 64'(want.neg));
                    check_value("result_bcd", 64'(result_bcd), 64'(want.bcd));
                end
            end
        end
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge rst);
        $display("watchdog expired after %0d cycles", watchdog_cycles);
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        digit_keys = '0;
        op_keys = '0;
        apply_reset();
        check_value("result_valid", 64'(result_valid), 64'h0);
        check_value("result_neg", 64'(result_neg), 64'h0);
        check_value("result_bcd", 64'(result_bcd), 64'h0);
        check_value("overflow", 64'(overflow), 64'h0);

        // half an expression must not produce a result
        load(0, 123, calc_pkg::op_add);
        load(1, 4567, calc_pkg::op_equ);
        enter_number(123);
        press_op(calc_pkg::op_add);
        repeat (40) @(negedge rst);
        check_value("result_count", 64'(results_seen), 64'h0);
        run_expr(1);

        load(0, 5, calc_pkg::op_sub);
        load(1, 12, calc_pkg::op_equ);
        run_expr(0);
        load(0, 2147483647, calc_pkg::op_add);
        load(1, 1, calc_pkg::op_equ);
        run_expr(0);
        load(0, 0, calc_pkg::op_sub);
        load(1, 7, calc_pkg::op_div);
        load(2, 2, calc_pkg::op_equ);
        run_expr(0);
        load(0, 12, calc_pkg::op_mul);
        load(1, 34, calc_pkg::op_div);
        load(2, 5, calc_pkg::op_equ);
        run_expr(0);
        load(0, 9, calc_pkg::op_div);
        load(1, 0, calc_pkg::op_equ);
        run_expr(0);

        for (int e = 0; e < 20; e++)
        begin
            lcg_state = lcg_next(lcg_state);
            nterms = 2 + int'(lcg_state[31:16] % 4);
            for (int i = 0; i < nterms; i++)
            begin
                lcg_state = lcg_next(lcg_state);
                terms[i] = lcg_state[31:8] % 1000000;
                lcg_state = lcg_next(lcg_state);
                ops[i] = calc_pkg::op_t'(lcg_state[31:30]);
            end
            ops[nterms-1] = calc_pkg::op_equ;
            run_expr(0);
        end

        // operators queue up behind a running conversion
        check_value("overflow", 64'(overflow), 64'h0);
        load(0, 0, calc_pkg::op_sub);
        load(1, 97, calc_pkg::op_equ);
        enter_number(0);
        press_op(calc_pkg::op_sub);
        enter_number(97);
        expected_q.push_back(calc_reference(2));
        results_expected++;
        press_op(calc_pkg::op_equ);
        for (int i = 0; i < 6; i++)
            press_op(calc_pkg::op_t'(i % 4));
        repeat (2) @(negedge rst);
        check_value("overflow", 64'(overflow), 64'h1);
        wait_result();
        repeat (50) @(negedge rst);
        check_value("overflow", 64'(overflow), 64'h1);   // sticky
        apply_reset();
        check_value("overflow", 64'(overflow), 64'h0);
        check_value("result_neg", 64'(result_neg), 64'h0);
        check_value("result_bcd", 64'(result_bcd), 64'h0);

        if (results_seen != results_expected)
        begin
            $display("saw %0d results but expected %0d", results_seen, results_expected);
            protocol_errors++;
        end
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/calculator_top.sv
`timescale 1ns/1ps
`default_nettype none

module calculator_top (
    input  logic                  rst,
    input  logic                  clk_100hz,
    input  calc_pkg::digit_keys_t digit_keys,
    input  calc_pkg::op_keys_t    op_keys,
    output logic                  result_valid,
    output logic                  result_neg,
    output calc_pkg::bcd_result_t result_bcd,
    output logic                  overflow
);

    logic               wr_en;
    calc_pkg::token_t   wr_token;
    calc_pkg::token_t   head;
    logic               not_empty;
    logic               rd_en;
    logic               conv_busy;
    logic               conv_start;
    calc_pkg::operand_t conv_value;

    key_entry u_key_entry (
        .rst        (rst),
        .clk_100hz  (clk_100hz),
        .digit_keys (digit_keys),
        .op_keys    (op_keys),
        .wr_en      (wr_en),
        .wr_token   (wr_token)
    );

    token_fifo u_token_fifo (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .wr_en     (wr_en),
        .wr_token  (wr_token),
        .rd_en     (rd_en),
        .head      (head),
        .not_empty (not_empty),
        .overflow  (overflow)
    );

    arith_unit u_arith_unit (
        .rst        (rst),
        .clk_100hz  (clk_100hz),
        .head       (head),
        .not_empty  (not_empty),
        .conv_busy  (conv_busy),
        .rd_en      (rd_en),
        .conv_start (conv_start),
        .conv_value (conv_value)
    );

    bcd_converter u_bcd_converter (
        .rst          (rst),
        .clk_100hz    (clk_100hz),
        .conv_start   (conv_start),
        .conv_value   (conv_value),
        .conv_busy    (conv_busy),
        .result_valid (result_valid),
        .result_neg   (result_neg),
        .result_bcd   (result_bcd)
    );

endmodule

`default_nettype wire

//--- src/bcd_converter.sv
`timescale 1ns/1ps
`default_nettype none

module bcd_converter (
    input  logic                  rst,
    input  logic                  clk_100hz,
    input  logic                  conv_start,
    input  calc_pkg::operand_t    conv_value,
    output logic                  conv_busy,
    output logic                  result_valid,
    output logic                  result_neg,
    output calc_pkg::bcd_result_t result_bcd
);

    calc_pkg::conv_state_t                  state;
    logic [$clog2(calc_pkg::conv_steps)-1:0] step;
    logic                                   sign_q;
    calc_pkg::operand_t                     mag;
    calc_pkg::bcd_result_t                  work;
    calc_pkg::bcd_result_t                  work_next;
    logic                                   last_step;

    assign conv_busy = state == calc_pkg::conv_shift;
    assign last_step = step == ($clog2(calc_pkg::conv_steps))'(calc_pkg::conv_steps - 1);

    // add 3 to digits of 5 or more, then shift in next magnitude bit
    always_comb
    begin
        calc_pkg::bcd_digit_t d;
        calc_pkg::bcd_result_t adj;
        adj = work;
        for (int i = 0; i < calc_pkg::bcd_digits; i++)
        begin
            d = work[4*i +: 4];
            if (d >= 4'd5)
                adj[4*i +: 4] = d + 4'd3;
        end
        work_next = {adj[4*calc_pkg::bcd_digits-2:0], mag[calc_pkg::operand_w-1]};
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            state        <= calc_pkg::conv_idle;
            step         <= '0;
            result_valid <= 1'b0;
            result_neg   <= 1'b0;
            result_bcd   <= '0;
        end
        else
        begin
            result_valid <= 1'b0;
            case (state)
                calc_pkg::conv_idle:
                begin
                    step <= '0;
                    if (conv_start)
                        state <= calc_pkg::conv_shift;
                end
                calc_pkg::conv_shift:
                begin
                    step <= step + 1'b1;
                    if (last_step)
                    begin
                        state        <= calc_pkg::conv_idle;
                        result_valid <= 1'b1;
                        result_neg   <= sign_q;
                        result_bcd   <= work_next;
                    end
                end
                default: state <= calc_pkg::conv_idle;
            endcase
        end
    end

    always_ff @(posedge rst)
    begin
        if (state == calc_pkg::conv_idle && conv_start)
        begin
            sign_q <= conv_value[calc_pkg::operand_w-1];
            // negating the most negative value leaves 2^31 as unsigned
            mag    <= conv_value[calc_pkg::operand_w-1] ? -conv_value : conv_value;
            work   <= '0;
        end
        else if (state == calc_pkg::conv_shift)
        begin
            work <= work_next;
            mag  <= mag << 1;
        end
    end

endmodule

`default_nettype wire

//--- src/arith_unit.sv
`timescale 1ns/1ps
`default_nettype none

module arith_unit (
    input  logic               rst,
    input  logic               clk_100hz,
    input  calc_pkg::token_t   head,
    input  logic               not_empty,
    input  logic               conv_busy,
    output logic               rd_en,
    output logic               conv_start,
    output calc_pkg::operand_t conv_value
);

    calc_pkg::operand_t acc;
    calc_pkg::op_t      pending;
    calc_pkg::operand_t result;

    function automatic calc_pkg::operand_t apply_op(input calc_pkg::operand_t a,
                                                    input calc_pkg::op_t      op,
                                                    input calc_pkg::operand_t b);
        calc_pkg::operand_t r;
        case (op)
            calc_pkg::op_add: r = a + b;
            calc_pkg::op_sub: r = a - b;
            calc_pkg::op_mul: r = a * b;    // low 32 bits match signed product
            calc_pkg::op_div:
            begin
                if (b == '0)
                    r = '0;
                else if (b == '1)
                    r = -a;                 // -1 divisor, wraps on most negative
                else
                    r = calc_pkg::operand_t'($signed(a) / $signed(b));
            end
            default: r = a;
        endcase
        return r;
    endfunction

    // hold off while converting or launching
    assign rd_en  = not_empty & ~conv_busy & ~conv_start;
    assign result = apply_op(acc, pending, head.operand);

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            acc        <= '0;
            pending    <= calc_pkg::op_add;
            conv_start <= 1'b0;
        end
        else
        begin
            conv_start <= rd_en && head.op == calc_pkg::op_equ;
            if (rd_en)
            begin
                if (head.op == calc_pkg::op_equ)
                begin
                    acc     <= '0;   // fresh expression
                    pending <= calc_pkg::op_add;
                end
                else
                begin
                    acc     <= result;
                    pending <= head.op;
                end
            end
        end
    end

    always_ff @(posedge rst)
    begin
        if (rd_en && head.op == calc_pkg::op_equ)
            conv_value <= result;
    end

endmodule

`default_nettype wire

//--- src/token_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module token_fifo (
    input  logic             rst,
    input  logic             clk_100hz,
    input  logic             wr_en,
    input  calc_pkg::token_t wr_token,
    input  logic             rd_en,
    output calc_pkg::token_t head,
    output logic             not_empty,
    output logic             overflow
);

    calc_pkg::token_t              mem [calc_pkg::fifo_depth];
    logic [calc_pkg::fifo_ptr_w-1:0] wr_ptr;
    logic [calc_pkg::fifo_ptr_w-1:0] rd_ptr;
    logic [calc_pkg::fifo_ptr_w:0]   count;
    logic                            full;
    logic                            do_wr;
    logic                            do_rd;

    assign full      = count == (calc_pkg::fifo_ptr_w + 1)'(calc_pkg::fifo_depth);
    assign not_empty = count != '0;
    assign do_wr     = wr_en & ~full;    // full drops the write
    assign do_rd     = rd_en & not_empty;
    assign head      = mem[rd_ptr];     // show-ahead

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
            if (wr_en && full)
                overflow <= 1'b1;   // sticky
        end
    end

    always_ff @(posedge rst)
    begin
        if (do_wr)
            mem[wr_ptr] <= wr_token;
    end

endmodule

`default_nettype wire

//--- src/key_entry.sv
`timescale 1ns/1ps
`default_nettype none

module key_entry (
    input  logic                  rst,
    input  logic                  clk_100hz,
    input  calc_pkg::digit_keys_t digit_keys,
    input  calc_pkg::op_keys_t    op_keys,
    output logic                  wr_en,
    output calc_pkg::token_t      wr_token
);

    logic                 digit_prev;
    logic                 op_prev;
    logic                 digit_press;
    logic                 op_press;
    calc_pkg::bcd_digit_t digit_val;
    calc_pkg::op_t        op_sel;
    calc_pkg::operand_t   term;

    assign digit_press = (|digit_keys) & ~digit_prev;
    assign op_press    = (|op_keys) & ~op_prev;

    // lowest pressed digit wins
    always_comb
    begin
        digit_val = '0;
        for (int k = calc_pkg::num_digit_keys - 1; k >= 0; k--)
        begin
            if (digit_keys[k])
                digit_val = calc_pkg::bcd_digit_t'(k);
        end
    end

    always_comb
    begin
        if (op_keys[0])
            op_sel = calc_pkg::op_add;
        else if (op_keys[1])
            op_sel = calc_pkg::op_sub;
        else if (op_keys[2])
            op_sel = calc_pkg::op_mul;
        else if (op_keys[3])
            op_sel = calc_pkg::op_div;
        else
            op_sel = calc_pkg::op_equ;
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            digit_prev <= 1'b0;
            op_prev    <= 1'b0;
            wr_en      <= 1'b0;
            term       <= '0;
        end
        else
        begin
            digit_prev <= |digit_keys;
            op_prev    <= |op_keys;
            wr_en      <= op_press;
            if (op_press)
                term <= '0;   // operator closes the term
            else if (digit_press)
                term <= term * calc_pkg::operand_t'(10) + calc_pkg::operand_t'(digit_val);
        end
    end

    always_ff @(posedge rst)
    begin
        if (op_press)
        begin
            wr_token.operand <= term;
            wr_token.op      <= op_sel;
        end
    end

endmodule

`default_nettype wire

//--- src/calc_pkg.sv
`default_nettype none

package calc_pkg;

    localparam int operand_w      = 32;
    localparam int bcd_digits     = 10;
    localparam int conv_steps     = 32;   // one step per magnitude bit
    localparam int fifo_depth     = 4;
    localparam int fifo_ptr_w     = 2;
    localparam int num_digit_keys = 10;

    typedef logic [operand_w-1:0]      operand_t;     // two's complement
    typedef logic [3:0]                bcd_digit_t;
    typedef logic [4*bcd_digits-1:0]   bcd_result_t;  // digit 0 in low nibble
    typedef logic [num_digit_keys-1:0] digit_keys_t;

    // add, sub, mul, div, equals from bit 0 up
    typedef logic [4:0] op_keys_t;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_mul,
        op_div,
        op_equ
    } op_t;

    typedef struct packed {
        operand_t operand;
        op_t      op;
    } token_t;

    typedef enum logic {
        conv_idle,
        conv_shift
    } conv_state_t;

endpackage

`default_nettype wire
